// ==== filelist.f ====
+incdir+rtl
rtl/vic_pkg.sv
rtl/bus_phase_gen.sv
rtl/vic_regs.sv
rtl/raster_timing.sv
rtl/pixel_out.sv
rtl/vicii.sv
rtl/top.sv
test/vic_assertions.sv
test/tb_top.sv

// ==== rtl/bus_phase_gen.sv ====
`timescale 1ns/1ns
`include "vic_defines.svh"

module bus_phase_gen import vic_pkg::*; (
  input  logic        clk_dot4x,
  input  logic        arst_n,
  output bus_phase_t  phase,
  output logic        ras,
  output logic        cas,
  output logic [11:0] refresh_addr
);

  localparam int CNT_W = $clog2(`VIC_PHI_DIV);
  localparam logic [CNT_W-1:0] HALF      = CNT_W'(`VIC_PHI_DIV / 2); // first phi high count
  localparam logic [CNT_W-1:0] LAST      = CNT_W'(`VIC_PHI_DIV - 1);
  localparam logic [CNT_W-1:0] RISE      = HALF - 1'b1; // count before phi rises
  localparam logic [CNT_W-1:0] RAS_START = CNT_W'(4);
  localparam logic [CNT_W-1:0] CAS_START = CNT_W'(8);

  logic [CNT_W-1:0] cnt;         // position within phi period
  logic [7:0]       refresh_cnt; // dram row being refreshed

  always_ff @(posedge clk_dot4x or negedge arst_n) begin
    if (!arst_n) begin
      cnt         <= '0;    // held, phi low
      refresh_cnt <= 8'hff;
    end else begin
      cnt <= (cnt == LAST) ? '0 : cnt + 1'b1;
      if (cnt == RISE)
        refresh_cnt <= refresh_cnt - 8'd1; // one row per phi rising edge
    end
  end

  always_comb begin
    phase.phi        = (cnt >= HALF);
    phase.aec        = phase.phi;        // vic owns the bus in phi low
    phase.pix_stb    = (cnt[1:0] == 2'b00); // every 4th dot4x
    phase.cpu_commit = (cnt == LAST);    // phi falls on next edge
  end

  // dram strobes, active low, only in the vic half
  assign ras = !((cnt >= RAS_START) && (cnt < HALF));
  assign cas = !((cnt >= CAS_START) && (cnt < HALF));

  assign refresh_addr = 12'hf00 | {4'h0, refresh_cnt}; // refresh rows sit at $3fxx style

endmodule

// ==== rtl/pixel_out.sv ====
`timescale 1ns/1ns
`include "vic_defines.svh"

module pixel_out import vic_pkg::*; (
  input  logic        clk_dot4x,
  input  logic        arst_n,
  input  bus_phase_t  phase,
  input  raster_pos_t pos,
  input  vic_cfg_t    cfg,
  output rgb_t        rgb,
  output logic        active
);

  localparam logic [7:0] BX_LO = 8'(`VIC_BORDER_H);
  localparam logic [7:0] BX_HI = 8'(`VIC_H_ACTIVE - `VIC_BORDER_H);
  localparam logic [7:0] BY_LO = 8'(`VIC_BORDER_V);
  localparam logic [7:0] BY_HI = 8'(`VIC_V_ACTIVE - `VIC_BORDER_V);

  // c64 colors, top nibble of each 8-bit channel
  function automatic logic [11:0] palette(input color_t idx);
    case (idx)
      4'd0:    palette = 12'h000; // black
      4'd1:    palette = 12'hfff; // white
      4'd2:    palette = 12'h632; // red
      4'd3:    palette = 12'h7ab; // cyan
      4'd4:    palette = 12'h638; // purple
      4'd5:    palette = 12'h584; // green
      4'd6:    palette = 12'h327; // blue
      4'd7:    palette = 12'hbc6; // yellow
      4'd8:    palette = 12'h642; // orange
      4'd9:    palette = 12'h430; // brown
      4'd10:   palette = 12'h965; // light red
      4'd11:   palette = 12'h444; // dark grey
      4'd12:   palette = 12'h666; // grey
      4'd13:   palette = 12'h9d8; // light green
      4'd14:   palette = 12'h65b; // light blue
      default: palette = 12'h999; // light grey
    endcase
  endfunction

  logic   in_border;
  color_t pick;

  always_comb begin
    in_border = (pos.xpos < BX_LO) || (pos.xpos >= BX_HI) ||
                (pos.ypos < BY_LO) || (pos.ypos >= BY_HI);
    pick      = in_border ? cfg.border : cfg.background;
  end

  always_ff @(posedge clk_dot4x or negedge arst_n) begin
    if (!arst_n)
      active <= 1'b0;
    else if (phase.pix_stb)
      active <= pos.active; // aligned with rgb below
  end

  // pixel latched on the strobe, so it trails the counters by one pixel
  always_ff @(posedge clk_dot4x) begin
    if (phase.pix_stb)
      rgb <= pos.active ? rgb_t'(palette(pick)) : rgb_t'(12'h000); // black outside window
  end

endmodule

// ==== rtl/raster_timing.sv ====
`timescale 1ns/1ns
`include "vic_defines.svh"

module raster_timing import vic_pkg::*; (
  input  logic        clk_dot4x,
  input  logic        arst_n,
  input  bus_phase_t  phase,
  input  logic [7:0]  raster_cmp,
  output raster_pos_t pos,
  output logic        raster_match
);

  localparam logic [7:0] H_LAST   = 8'(`VIC_H_TOTAL - 1);
  localparam logic [7:0] V_LAST   = 8'(`VIC_V_TOTAL - 1);
  localparam logic [7:0] H_ACTIVE = 8'(`VIC_H_ACTIVE);
  localparam logic [7:0] V_ACTIVE = 8'(`VIC_V_ACTIVE);
  localparam logic [7:0] HS_START = 8'(`VIC_H_SYNC_START);
  localparam logic [7:0] HS_END   = 8'(`VIC_H_SYNC_START + `VIC_H_SYNC_LEN);
  localparam logic [7:0] VS_START = 8'(`VIC_V_SYNC_START);
  localparam logic [7:0] VS_END   = 8'(`VIC_V_SYNC_START + `VIC_V_SYNC_LEN);

  logic [7:0] xpos;
  logic [7:0] ypos;
  logic [7:0] ypos_next; // line after wrap
  logic       eol;       // last pixel of line

  assign eol       = (xpos == H_LAST);
  assign ypos_next = (ypos == V_LAST) ? 8'd0 : ypos + 8'd1;

  always_ff @(posedge clk_dot4x or negedge arst_n) begin
    if (!arst_n) begin
      xpos         <= 8'd0;
      ypos         <= 8'd0;
      raster_match <= 1'b0;
    end else begin
      raster_match <= 1'b0; // single cycle pulse
      if (phase.pix_stb) begin
        if (eol) begin
          xpos         <= 8'd0;
          ypos         <= ypos_next;
          raster_match <= (ypos_next == raster_cmp); // new line hits compare
        end else begin
          xpos <= xpos + 8'd1;
        end
      end
    end
  end

  // sync and window decode straight off the counters
  always_comb begin
    pos.xpos   = xpos;
    pos.ypos   = ypos;
    pos.active = (xpos < H_ACTIVE) && (ypos < V_ACTIVE);
    pos.hsync  = (xpos >= HS_START) && (xpos < HS_END); // active high
    pos.vsync  = (ypos >= VS_START) && (ypos < VS_END);
  end

endmodule

// ==== rtl/top.sv ====
`timescale 1ns/1ns

module top (
  input  logic        clk_dot4x,
  input  logic        arst_n,
  output logic        cpu_reset,      // holds the 6510 in reset
  output logic        clk_phi,        // cpu phi clock
  output logic        hsync,
  output logic        vsync,
  output logic        active,
  output logic [3:0]  red,
  output logic [3:0]  green,
  output logic [3:0]  blue,
  input  logic [5:0]  adl,            // address low, read side
  output logic [5:0]  adh,            // address high, vic side only
  input  logic [7:0]  dbl,            // ram/rom data
  input  logic [3:0]  dbh,            // color ram data
  output logic [7:0]  dbo_sim,
  output logic [11:0] ado_sim,
  input  logic        ce,             // low = enable
  input  logic        rw,             // high = read
  output logic        irq,
  input  logic        lp,             // light pen, not latched
  output logic        aec,
  output logic        ba,
  output logic        cas,
  output logic        ras,
  output logic        ls245_addr_oe,
  output logic        ls245_addr_dir,
  output logic        ls245_data_oe,
  output logic        ls245_data_dir
);

  logic [7:0]  dbo;
  logic [11:0] ado;
  logic        vic_write_ab;
  logic        vic_write_db;

  assign cpu_reset = !arst_n;

  vicii vicii_inst (
    .clk_dot4x      (clk_dot4x),
    .arst_n         (arst_n),
    .ce             (ce),
    .rw             (rw),
    .adi            (adl),
    .dbi            ({dbh, dbl}),
    .dbo            (dbo),
    .ado            (ado),
    .clk_phi        (clk_phi),
    .aec            (aec),
    .ba             (ba),
    .ras            (ras),
    .cas            (cas),
    .irq            (irq),
    .hsync          (hsync),
    .vsync          (vsync),
    .active         (active),
    .red            (red),
    .green          (green),
    .blue           (blue),
    .vic_write_db   (vic_write_db),
    .vic_write_ab   (vic_write_ab),
    .ls245_addr_oe  (ls245_addr_oe),
    .ls245_addr_dir (ls245_addr_dir),
    .ls245_data_oe  (ls245_data_oe),
    .ls245_data_dir (ls245_data_dir)
  );

  // split sim ports stand in for the tri-state pins
  assign adh     = vic_write_ab ? ado[11:6] : 6'h00;
  assign ado_sim = ado;
  assign dbo_sim = vic_write_db ? dbo : 8'hff; // bus floats high when not driven

endmodule

// ==== rtl/vic_defines.svh ====
`ifndef VIC_DEFINES_SVH
`define VIC_DEFINES_SVH

// phi clock divider, dot4x cycles per phi period
`define VIC_PHI_DIV 32

// horizontal raster, in pixels (shrunk for simulation)
`define VIC_H_TOTAL      64
`define VIC_H_ACTIVE     48
`define VIC_H_SYNC_START 52
`define VIC_H_SYNC_LEN   6

// vertical raster, in lines
`define VIC_V_TOTAL      16
`define VIC_V_ACTIVE     12
`define VIC_V_SYNC_START 13
`define VIC_V_SYNC_LEN   2

// border margins inside the active window
`define VIC_BORDER_H 8
`define VIC_BORDER_V 2

// register map, 6-bit CPU address
`define VIC_REG_RASTER   6'h12
`define VIC_REG_IRQ_STAT 6'h19
`define VIC_REG_IRQ_EN   6'h1a
`define VIC_REG_BORDER   6'h20
`define VIC_REG_BG       6'h21

`endif

// ==== rtl/vic_pkg.sv ====
package vic_pkg;

  // palette index
  typedef logic [3:0] color_t;

  // 4 bits per channel, red in the top nibble
  typedef struct packed {
    logic [3:0] red;
    logic [3:0] green;
    logic [3:0] blue;
  } rgb_t;

  // beam position and sync state
  typedef struct packed {
    logic [7:0] xpos;   // pixel within line
    logic [7:0] ypos;   // raster line
    logic       active; // visible window
    logic       hsync;
    logic       vsync;
  } raster_pos_t;

  // CPU-programmed configuration
  typedef struct packed {
    color_t     border;
    color_t     background;
    logic [7:0] raster_cmp; // irq line
    logic       irq_en;     // raster irq enable
  } vic_cfg_t;

  // bus phase decode from the phi divider
  typedef struct packed {
    logic phi;        // cpu clock
    logic aec;        // cpu owns address bus
    logic pix_stb;    // one dot4x pulse per pixel
    logic cpu_commit; // last cycle of phi high
  } bus_phase_t;

endpackage

// ==== rtl/vic_regs.sv ====
`timescale 1ns/1ns
`include "vic_defines.svh"

module vic_regs import vic_pkg::*; (
  input  logic        clk_dot4x,
  input  logic        arst_n,
  input  bus_phase_t  phase,
  input  raster_pos_t pos,
  input  logic        raster_match,
  input  logic        ce,          // low = selected
  input  logic        rw,          // high = read
  input  logic [5:0]  adl,
  input  logic [7:0]  dbi,
  output vic_cfg_t    cfg,
  output logic [7:0]  dbo,
  output logic        read_active,
  output logic        irq          // active low
);

  logic cpu_sel;    // cpu access window
  logic wr_commit;  // write lands this cycle
  logic stat_clr;   // write-one-to-clear on status
  logic irq_stat;   // raster irq pending

  assign cpu_sel     = !ce && phase.phi;
  assign wr_commit   = cpu_sel && !rw && phase.cpu_commit; // falling edge of phi
  assign read_active = cpu_sel && rw;
  assign stat_clr    = wr_commit && (adl == `VIC_REG_IRQ_STAT) && dbi[0];

  always_ff @(posedge clk_dot4x or negedge arst_n) begin
    if (!arst_n) begin
      cfg      <= '0;
      irq_stat <= 1'b0;
      irq      <= 1'b1; // released
    end else begin
      if (wr_commit) begin
        case (adl)
          `VIC_REG_RASTER: cfg.raster_cmp <= dbi;
          `VIC_REG_IRQ_EN: cfg.irq_en     <= dbi[0];
          `VIC_REG_BORDER: cfg.border     <= color_t'(dbi[3:0]);
          `VIC_REG_BG:     cfg.background <= color_t'(dbi[3:0]);
          default: ;
        endcase
      end

      // a new match wins over a clear in the same cycle
      if (raster_match)
        irq_stat <= 1'b1;
      else if (stat_clr)
        irq_stat <= 1'b0;

      irq <= !(irq_stat && cfg.irq_en); // one cycle behind the status
    end
  end

  // read mux, unused bits read back as ones
  always_comb begin
    case (adl)
      `VIC_REG_RASTER:   dbo = pos.ypos;                    // live line
      `VIC_REG_IRQ_STAT: dbo = {!irq, 6'b000000, irq_stat}; // bit 7 = irq asserted
      `VIC_REG_IRQ_EN:   dbo = {7'h7f, cfg.irq_en};
      `VIC_REG_BORDER:   dbo = {4'hf, cfg.border};
      `VIC_REG_BG:       dbo = {4'hf, cfg.background};
      default:           dbo = 8'hff;                       // unmapped
    endcase
  end

endmodule

// ==== rtl/vicii.sv ====
`timescale 1ns/1ns

module vicii import vic_pkg::*; (
  input  logic        clk_dot4x,
  input  logic        arst_n,
  input  logic        ce,           // low = enable
  input  logic        rw,           // high = read
  input  logic [5:0]  adi,
  input  logic [11:0] dbi,          // {color nibble, data}
  output logic [7:0]  dbo,
  output logic [11:0] ado,
  output logic        clk_phi,
  output logic        aec,
  output logic        ba,
  output logic        ras,
  output logic        cas,
  output logic        irq,
  output logic        hsync,
  output logic        vsync,
  output logic        active,
  output logic [3:0]  red,
  output logic [3:0]  green,
  output logic [3:0]  blue,
  output logic        vic_write_db,
  output logic        vic_write_ab,
  output logic        ls245_addr_oe,
  output logic        ls245_addr_dir,
  output logic        ls245_data_oe,
  output logic        ls245_data_dir
);

  bus_phase_t  phase;
  raster_pos_t pos;
  vic_cfg_t    cfg;
  rgb_t        rgb;
  logic [11:0] refresh_addr;
  logic        raster_match;
  logic        read_active;

  bus_phase_gen bus_phase_gen_inst (
    .clk_dot4x    (clk_dot4x),
    .arst_n       (arst_n),
    .phase        (phase),
    .ras          (ras),
    .cas          (cas),
    .refresh_addr (refresh_addr)
  );

  vic_regs vic_regs_inst (
    .clk_dot4x    (clk_dot4x),
    .arst_n       (arst_n),
    .phase        (phase),
    .pos          (pos),
    .raster_match (raster_match),
    .ce           (ce),
    .rw           (rw),
    .adl          (adi),
    .dbi          (dbi[7:0]),   // color nibble only matters for fetches
    .cfg          (cfg),
    .dbo          (dbo),
    .read_active  (read_active),
    .irq          (irq)
  );

  raster_timing raster_timing_inst (
    .clk_dot4x    (clk_dot4x),
    .arst_n       (arst_n),
    .phase        (phase),
    .raster_cmp   (cfg.raster_cmp),
    .pos          (pos),
    .raster_match (raster_match)
  );

  pixel_out pixel_out_inst (
    .clk_dot4x (clk_dot4x),
    .arst_n    (arst_n),
    .phase     (phase),
    .pos       (pos),
    .cfg       (cfg),
    .rgb       (rgb),
    .active    (active)
  );

  assign clk_phi = phase.phi;
  assign aec     = phase.aec;
  assign ba      = 1'b1;          // no badlines, cpu never stalled
  assign ado     = refresh_addr;  // only refresh cycles use the bus

  // vic drives the address bus in phi low, data bus on cpu reads
  assign vic_write_ab = !phase.phi;
  assign vic_write_db = read_active;

  assign ls245_addr_oe  = 1'b0;                   // always enabled
  assign ls245_addr_dir = vic_write_ab;
  assign ls245_data_oe  = !(!ce && phase.phi);    // open in the cpu window
  assign ls245_data_dir = vic_write_db;

  assign hsync = pos.hsync;
  assign vsync = pos.vsync;
  assign red   = rgb.red;
  assign green = rgb.green;
  assign blue  = rgb.blue;

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the testbench with verilator, result taken from the log
set -e
set -o pipefail

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module tb_top -Mdir obj_dir -f filelist.f

./obj_dir/Vtb_top 2>&1 | tee sim.log

if grep -q ">>> FAIL" sim.log; then
  echo "simulation reported failure"
  exit 1
fi
echo "simulation finished without failure"

// ==== test/tb_top.sv ====
`timescale 1ns/1ns
`include "vic_defines.svh"

module tb_top;

  logic        clk_dot4x;
  logic        arst_n;
  logic        ce;
  logic        rw;
  logic        lp;
  logic [5:0]  adl;
  logic [7:0]  dbl;
  logic [3:0]  dbh;
  logic        cpu_reset;
  logic        clk_phi;
  logic        hsync;
  logic        vsync;
  logic        active;
  logic [3:0]  red;
  logic [3:0]  green;
  logic [3:0]  blue;
  logic [5:0]  adh;
  logic [7:0]  dbo_sim;
  logic [11:0] ado_sim;
  logic        irq;
  logic        aec;
  logic        ba;
  logic        cas;
  logic        ras;
  logic        ls245_addr_oe;
  logic        ls245_addr_dir;
  logic        ls245_data_oe;
  logic        ls245_data_dir;

  int          errors = 0;
  int          checks = 0;
  logic [31:0] seed = 32'h95d9;
  logic [3:0]  border_c = 4'h0;  // colors the cpu wrote last
  logic [3:0]  bg_c = 4'h0;
  logic        pix_check_en = 1'b0;
  int          pix_checks = 0;
  int          phi_periods = 0;

  // c64 palette at 4 bits per channel starting at index 0
  localparam logic [11:0] PALETTE [16] = '{
    12'h000, 12'hfff, 12'h632, 12'h7ab, 12'h638, 12'h584, 12'h327, 12'hbc6,
    12'h642, 12'h430, 12'h965, 12'h444, 12'h666, 12'h9d8, 12'h65b, 12'h999
  };

  top top_inst (.*);

  initial begin
    clk_dot4x = 1'b0;
    forever #20 clk_dot4x = ~clk_dot4x; // 40 ns dot4x
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // expected beam color for a pixel of the visible frame
  function automatic logic [11:0] expected_pixel(input int x, input int y,
                                                 input logic [3:0] bdr, input logic [3:0] bg);
    if (x >= `VIC_H_ACTIVE || y >= `VIC_V_ACTIVE)
      return 12'h000; // blanked
    if (x < `VIC_BORDER_H || x >= `VIC_H_ACTIVE - `VIC_BORDER_H ||
        y < `VIC_BORDER_V || y >= `VIC_V_ACTIVE - `VIC_BORDER_V)
      return PALETTE[bdr];
    return PALETTE[bg];
  endfunction

  function automatic logic [11:0] refresh_address(input logic [7:0] row);
    return {4'hf, row}; // refresh page at f00h
  endfunction

  // cpu read value of the static registers
  function automatic logic [7:0] register_value(input logic [5:0] addr, input logic [3:0] bdr,
                                                input logic [3:0] bg, input logic stat,
                                                input logic irq_on);
    case (addr)
      `VIC_REG_BORDER:   return {4'hf, bdr};
      `VIC_REG_BG:       return {4'hf, bg};
      `VIC_REG_IRQ_STAT: return {irq_on, 6'd0, stat};
      default:           return 8'hff;
    endcase
  endfunction

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (exp === act) else begin
      errors++;
      $display("FAILED %s: expected %0h, actual %0h", name, exp, act);
    end
  endtask

  task automatic expect_true(input logic cond, input string what);
    checks++;
    assert (cond === 1'b1) else begin
      errors++;
      $display("error: %s", what);
    end
  endtask

  task automatic abort_timeout(input string what);
    $display("timeout waiting for %s, %0d errors so far", what, errors);
    $display(">>> FAIL");
    $finish;
  endtask

  // steps at least one negedge and stops once phi reaches level
  task automatic wait_phi(input logic level);
    int n;
    n = 0;
    do begin
      @(negedge clk_dot4x);
      n++;
    end while (clk_phi !== level && n < 64);
    if (clk_phi !== level)
      abort_timeout("phi edge");
  endtask

  task automatic skip_phi(input int periods);
    repeat (periods) begin
      wait_phi(1'b1);
      wait_phi(1'b0);
    end
  endtask

  // one cpu cycle taking exactly one phi period
  task automatic bus_access(input logic rd, input logic [5:0] addr, input logic [7:0] wdata,
                            output logic [7:0] rdata, output logic drv);
    wait_phi(1'b0);
    wait_phi(1'b1);
    @(posedge clk_dot4x);
    ce  <= 1'b0;
    rw  <= rd;
    adl <= addr;
    dbl <= wdata;
    @(negedge clk_dot4x);
    rdata = dbo_sim;
    drv   = ls245_data_dir && !ls245_data_oe; // vic drives the data bus
    wait_phi(1'b0);                            // write lands on the phi fall
    @(posedge clk_dot4x);
    ce <= 1'b1;
    rw <= 1'b1;
  endtask

  task automatic write_reg(input logic [5:0] addr, input logic [7:0] data);
    logic [7:0] unused_rd;
    logic       unused_drv;
    bus_access(1'b0, addr, data, unused_rd, unused_drv);
  endtask

  task automatic read_reg(input logic [5:0] addr, output logic [7:0] data);
    logic drv;
    bus_access(1'b1, addr, 8'h00, data, drv);
    expect_true(drv, "data bus not driven by the vic during a read");
  endtask

  // bus phase and refresh monitor
  logic       phi_prev = 1'b0;
  logic       phi_armed = 1'b0;
  int         half_len = 0;
  logic [7:0] refresh_row = 8'hff;
  logic [11:0] exp_ado;

  always @(negedge clk_dot4x) begin
    check("cpu_reset", 32'(!arst_n), 32'(cpu_reset));
    if (arst_n) begin
      if (clk_phi !== phi_prev) begin
        if (phi_armed)
          check("phi half length", 32'd16, 32'(half_len));
        phi_armed = 1'b1;
        half_len  = 1;
        if (clk_phi) begin
          refresh_row = refresh_row - 8'd1; // one row per phi rise
          phi_periods++;
        end
      end else begin
        half_len++;
      end
      phi_prev = clk_phi;
      check("aec", 32'(clk_phi), 32'(aec));
      check("ls245_addr_oe", 32'd0, 32'(ls245_addr_oe));             // address buffer always on
      check("ls245_addr_dir", 32'(!clk_phi), 32'(ls245_addr_dir)); // vic side in phi low
      if (phi_armed) begin
        // half_len - 1 is the phase count while phi is low
        check("ras", 32'(clk_phi || half_len <= 4), 32'(ras));
        check("cas", 32'(clk_phi || half_len <= 8), 32'(cas));
      end
      if (!clk_phi) begin
        exp_ado = refresh_address(refresh_row);
        check("refresh address", 32'(exp_ado), 32'(ado_sim));
        check("adh", 32'(exp_ado[11:6]), 32'(adh));
      end
    end
  end

  // pixel monitor with the beam position rebuilt from the sync edges
  int   tx = 0;
  int   ty = 0;
  int   sub = 0;
  logic hs_prev = 1'b0;
  logic vs_prev = 1'b0;
  logic hs_seen = 1'b0;
  logic vs_seen = 1'b0;

  always @(negedge clk_dot4x) begin
    if (arst_n) begin
      sub = sub + 1;
      if (sub == 4) begin // next pixel on the output
        sub = 0;
        tx  = (tx + 1) % `VIC_H_TOTAL;
        if (tx == 0)
          ty = (ty + 1) % `VIC_V_TOTAL;
      end
      if (hsync && !hs_prev) begin
        tx      = `VIC_H_SYNC_START - 1; // rgb trails the counters by a pixel
        sub     = 0;
        hs_seen = 1'b1;
      end
      if (vsync && !vs_prev) begin
        ty      = `VIC_V_SYNC_START - 1;
        vs_seen = 1'b1;
      end
      hs_prev = hsync;
      vs_prev = vsync;
      if (pix_check_en && hs_seen && vs_seen && sub == 0) begin
        pix_checks++;
        check("pixel rgb", 32'(expected_pixel(tx, ty, border_c, bg_c)), 32'({red, green, blue}));
        check("pixel active", 32'(tx < `VIC_H_ACTIVE && ty < `VIC_V_ACTIVE), 32'(active));
      end
    end
  end

  initial begin
    logic [7:0] rdata;
    logic [7:0] y0;
    logic [7:0] y1;
    logic [7:0] cmp;
    logic       vs_last;
    logic       quiet;
    int         frames;
    int         n;

    arst_n <= 1'b0;
    ce     <= 1'b1;
    rw     <= 1'b1;
    adl    <= 6'h00;
    dbl    <= 8'h00;
    dbh    <= 4'h0;
    lp     <= 1'b1;
    repeat (10) @(posedge clk_dot4x);
    arst_n <= 1'b1;

    // color registers written and read back
    repeat (4) begin
      seed     = lcg_next(seed);
      border_c = seed[19:16];
      bg_c     = seed[23:20];
      write_reg(`VIC_REG_BORDER, {4'h0, border_c});
      write_reg(`VIC_REG_BG, {4'h0, bg_c});
      read_reg(`VIC_REG_BORDER, rdata);
      check("border readback",
            32'(register_value(`VIC_REG_BORDER, border_c, bg_c, 1'b0, 1'b0)), 32'(rdata));
      read_reg(`VIC_REG_BG, rdata);
      check("background readback",
            32'(register_value(`VIC_REG_BG, border_c, bg_c, 1'b0, 1'b0)), 32'(rdata));
    end
    read_reg(6'h3f, rdata);
    check("unmapped read", 32'(register_value(6'h3f, border_c, bg_c, 1'b0, 1'b0)), 32'(rdata));
    check("ba", 32'd1, 32'(ba));

    // raster line advances once per 8 phi periods
    repeat (3) begin
      read_reg(`VIC_REG_RASTER, y0);
      expect_true(int'(y0) < `VIC_V_TOTAL, "raster line outside the frame");
      skip_phi(7);
      read_reg(`VIC_REG_RASTER, y1);
      check("raster step", 32'((int'(y0) + 1) % `VIC_V_TOTAL), 32'(y1));
    end

    // pixel path over a full frame with fresh colors
    seed     = lcg_next(seed);
    border_c = seed[19:16];
    bg_c     = seed[23:20];
    write_reg(`VIC_REG_BORDER, {4'h0, border_c});
    write_reg(`VIC_REG_BG, {4'h0, bg_c});
    skip_phi(1); // let the old colors drain out of the rgb register
    pix_check_en = 1'b1;
    frames  = 0;
    n       = 0;
    vs_last = vsync;
    while (frames < 2 && n < 3 * 4096) begin
      @(negedge clk_dot4x);
      n++;
      if (vsync && !vs_last)
        frames++;
      vs_last = vsync;
    end
    if (frames < 2)
      abort_timeout("two frames of vsync");
    pix_check_en = 1'b0;
    expect_true(pix_checks > 0, "no pixels were compared");

    // raster interrupt
    seed = lcg_next(seed);
    cmp  = {4'h0, seed[19:16]};
    write_reg(`VIC_REG_RASTER, cmp);
    write_reg(`VIC_REG_IRQ_STAT, 8'h01); // drop matches on the old line
    write_reg(`VIC_REG_IRQ_EN, 8'h01);
    n = 0;
    while (irq !== 1'b0 && n < 3 * 4096) begin
      @(negedge clk_dot4x);
      n++;
    end
    if (irq !== 1'b0)
      abort_timeout("raster irq");
    read_reg(`VIC_REG_RASTER, rdata);
    check("irq raster line", 32'(cmp), 32'(rdata));
    read_reg(`VIC_REG_IRQ_STAT, rdata);
    check("irq status",
          32'(register_value(`VIC_REG_IRQ_STAT, border_c, bg_c, 1'b1, 1'b1)), 32'(rdata));
    write_reg(`VIC_REG_IRQ_STAT, 8'h01);
    n = 0;
    while (irq !== 1'b1 && n < 8) begin
      @(negedge clk_dot4x);
      n++;
    end
    expect_true(irq === 1'b1, "irq still asserted after clearing the status bit");

    // a whole frame passes quietly with the irq disabled
    write_reg(`VIC_REG_IRQ_EN, 8'h00);
    quiet = 1'b1;
    repeat (4096 + 256) begin
      @(negedge clk_dot4x);
      if (irq !== 1'b1)
        quiet = 1'b0;
    end
    expect_true(quiet, "irq asserted with the enable bit clear");
    read_reg(`VIC_REG_IRQ_STAT, rdata); // match still latched without irq
    check("status without enable",
          32'(register_value(`VIC_REG_IRQ_STAT, border_c, bg_c, 1'b1, 1'b0)), 32'(rdata));

    expect_true(phi_periods > 256, "refresh counter never wrapped");
    $display("checks %0d, errors %0d, pixels %0d", checks, errors, pix_checks);
    if (errors == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

// ==== test/vic_assertions.sv ====
`timescale 1ns/1ns

module vic_assertions (
  input logic clk_dot4x,
  input logic arst_n,
  input logic clk_phi,
  input logic aec,
  input logic vic_write_db,
  input logic ras,
  input logic cas
);

  logic       phi_q;   // phi one cycle back
  logic       armed;   // first phi edge seen
  logic [5:0] run_len; // cycles since last phi edge

  always_ff @(posedge clk_dot4x or negedge arst_n) begin
    if (!arst_n) begin
      phi_q   <= 1'b0;
      armed   <= 1'b0;
      run_len <= 6'd0;
    end else begin
      phi_q <= clk_phi;
      if (clk_phi != phi_q) begin
        run_len <= 6'd1;
        armed   <= 1'b1;
      end else begin
        run_len <= run_len + 6'd1;
      end
    end
  end

  phi_half_len: assert property (@(posedge clk_dot4x) disable iff (!arst_n)
    (armed && clk_phi != phi_q) |-> run_len == 6'd16)
    else $error("phi changed after %0d cycles", run_len);

  aec_is_phi: assert property (@(posedge clk_dot4x) disable iff (!arst_n) aec == clk_phi)
    else $error("aec differs from phi");

  // data bus only driven in the cpu half
  db_in_phi_high: assert property (@(posedge clk_dot4x) disable iff (!arst_n)
    !clk_phi |-> !vic_write_db)
    else $error("vic drives data bus while phi is low");

  cas_inside_ras: assert property (@(posedge clk_dot4x) disable iff (!arst_n) !cas |-> !ras)
    else $error("cas low without ras");

endmodule

bind vicii vic_assertions vic_assertions_inst (
  .clk_dot4x    (clk_dot4x),
  .arst_n       (arst_n),
  .clk_phi      (clk_phi),
  .aec          (aec),
  .vic_write_db (vic_write_db),
  .ras          (ras),
  .cas          (cas)
);
